// File: logic/backend_defs.svh
`ifndef BACKEND_DEFS_SVH
`define BACKEND_DEFS_SVH

// Data, operand and address width
`define DATA_W     16
`define NUM_REGS   8
`define REG_IDX_W  3
// Four multiplier bits per stage
`define MUL_STAGES 4

`endif

// File: logic/backend_pkg.sv
`include "backend_defs.svh"

package backend_pkg;

  typedef enum logic [1:0] {
    OP_ADD  = 2'd0,
    OP_SUB  = 2'd1,
    OP_MUL  = 2'd2,
    OP_LOAD = 2'd3
  } opcode_e;

  typedef enum logic [1:0] {
    MEM_IDLE    = 2'd0,
    MEM_REQ     = 2'd1,
    MEM_RELEASE = 2'd2
  } mem_state_e;

  // Decode-side view used for hazard detection
  typedef struct packed {
    logic [`REG_IDX_W-1:0] rs1;
    logic [`REG_IDX_W-1:0] rs2;
    logic [`REG_IDX_W-1:0] rd;
    logic                  rs1_needed;
    logic                  rs2_needed;
    logic                  is_mul;
  } hazard_ctrl_t;

endpackage : backend_pkg

// File: logic/op_if.sv
`timescale 1ns/100ps
`include "backend_defs.svh"

interface op_if import backend_pkg::*; ();

  logic                  valid;
  opcode_e               op;
  logic [`REG_IDX_W-1:0] rd;
  logic [`DATA_W-1:0]    opa;
  logic [`DATA_W-1:0]    opb;
  // Running result that ends as the written value
  logic [`DATA_W-1:0]    acc;

  modport src (output valid, op, rd, opa, opb, acc);
  modport dst (input valid, op, rd, opa, opb, acc);

endinterface : op_if

// File: logic/issue_stage.sv
`timescale 1ns/100ps
`include "backend_defs.svh"

module issue_stage import backend_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  instr_valid_i,
  input  opcode_e               instr_op_i,
  input  logic [`REG_IDX_W-1:0] instr_rd_i,
  input  logic [`REG_IDX_W-1:0] instr_rs1_i,
  input  logic [`REG_IDX_W-1:0] instr_rs2_i,
  input  logic [`DATA_W-1:0]    instr_imm_i,
  output logic                  instr_ready_o,
  input  logic                  stall_decode_i,
  input  logic                  alu_bubble_i,
  input  logic                  ex_bubble_i,
  input  logic                  wr_en_i,
  input  logic [`REG_IDX_W-1:0] wr_rd_i,
  input  logic [`DATA_W-1:0]    wr_data_i,
  output hazard_ctrl_t          hazard_o,
  op_if.src                     alu_out,
  op_if.src                     mul_out
);

  logic                  dec_valid_q;
  opcode_e               dec_op_q;
  logic [`REG_IDX_W-1:0] dec_rd_q;
  logic [`REG_IDX_W-1:0] dec_rs1_q;
  logic [`REG_IDX_W-1:0] dec_rs2_q;
  logic [`DATA_W-1:0]    dec_imm_q;
  logic [`DATA_W-1:0]    regs_q [`NUM_REGS];
  logic [`DATA_W-1:0]    rs1_val;
  logic [`DATA_W-1:0]    rs2_val;
  logic                  is_mul;

  // Empty or leaving this cycle
  assign instr_ready_o = !dec_valid_q || !stall_decode_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dec_valid_q <= 1'b0;
    end else if (instr_ready_o) begin
      dec_valid_q <= instr_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_valid_i && instr_ready_o) begin
      dec_op_q  <= instr_op_i;
      dec_rd_q  <= instr_rd_i;
      dec_rs1_q <= instr_rs1_i;
      dec_rs2_q <= instr_rs2_i;
      dec_imm_q <= instr_imm_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i && wr_rd_i != '0) begin
      regs_q[wr_rd_i] <= wr_data_i;
    end
  end

  // Same-cycle write is visible to the read
  assign rs1_val = (dec_rs1_q == '0) ? '0 :
                   (wr_en_i && wr_rd_i == dec_rs1_q) ? wr_data_i : regs_q[dec_rs1_q];
  assign rs2_val = (dec_rs2_q == '0) ? '0 :
                   (wr_en_i && wr_rd_i == dec_rs2_q) ? wr_data_i : regs_q[dec_rs2_q];

  assign is_mul = (dec_op_q == OP_MUL);

  assign alu_out.valid = dec_valid_q && !is_mul && !alu_bubble_i;
  assign alu_out.op    = dec_op_q;
  assign alu_out.rd    = dec_rd_q;
  assign alu_out.opa   = rs1_val;
  assign alu_out.opb   = (dec_op_q == OP_LOAD) ? dec_imm_q : rs2_val;
  assign alu_out.acc   = '0;

  assign mul_out.valid = dec_valid_q && is_mul && !ex_bubble_i;
  assign mul_out.op    = dec_op_q;
  assign mul_out.rd    = dec_rd_q;
  assign mul_out.opa   = rs1_val;
  assign mul_out.opb   = rs2_val;
  assign mul_out.acc   = '0;

  assign hazard_o.rs1        = dec_rs1_q;
  assign hazard_o.rs2        = dec_rs2_q;
  assign hazard_o.rd         = dec_rd_q;
  // Every opcode reads rs1
  assign hazard_o.rs1_needed = dec_valid_q;
  // LOAD takes imm in place of rs2
  assign hazard_o.rs2_needed = (dec_op_q != OP_LOAD);
  assign hazard_o.is_mul     = is_mul;

endmodule : issue_stage

// File: logic/hazard_unit.sv
`timescale 1ns/100ps
`include "backend_defs.svh"

module hazard_unit import backend_pkg::*; (
  input  logic                                   dec_valid_i,
  input  hazard_ctrl_t                           hazard_i,
  input  logic                                   alu_valid_i,
  input  logic                                   alu_is_load_i,
  input  logic [`REG_IDX_W-1:0]                  alu_wr_reg_i,
  input  logic                                   mem_valid_i,
  input  logic                                   mem_busy_i,
  input  logic [`REG_IDX_W-1:0]                  mem_wr_reg_i,
  input  logic [`MUL_STAGES-1:0]                 mul_valid_i,
  input  logic [`MUL_STAGES-1:0][`REG_IDX_W-1:0] mul_wr_reg_i,
  input  logic                                   mul_allowed_wb_i,
  input  logic                                   alu_allowed_wb_i,
  output logic [`MUL_STAGES-1:0]                 stall_mul_o,
  output logic                                   stall_alu_o,
  output logic                                   stall_decode_o,
  output logic                                   alu_bubble_o,
  output logic                                   ex_bubble_o
);

  logic alu_hazard;
  logic mem_hazard;
  logic mul_hazard;
  logic ex_backpressure;
  logic alu_backpressure;

  // Needed sources and rd against one in-flight destination other than r0
  function automatic logic reg_conflict(input hazard_ctrl_t hz,
                                        input logic [`REG_IDX_W-1:0] idx);
    logic hit;
    hit = (hz.rs1_needed && hz.rs1 == idx) ||
          (hz.rs2_needed && hz.rs2 == idx) ||
          (hz.rd == idx);
    return hit && (idx != '0);
  endfunction

  // Ripples back through occupied stages only
  always_comb begin : mul_stall_chain
    logic stall_next;
    stall_next = !mul_allowed_wb_i;
    for (int i = `MUL_STAGES-1; i >= 0; i--) begin
      stall_next     = stall_next && mul_valid_i[i];
      stall_mul_o[i] = stall_next;
    end
  end

  // LOAD waits on the memory stage, other ops on the write port
  assign stall_alu_o = alu_valid_i && (alu_is_load_i ? mem_busy_i : !alu_allowed_wb_i);

  always_comb begin : mul_raw_waw
    mul_hazard = 1'b0;
    for (int i = 0; i < `MUL_STAGES; i++) begin
      if (mul_valid_i[i] && reg_conflict(hazard_i, mul_wr_reg_i[i])) begin
        mul_hazard = 1'b1;
      end
    end
  end

  assign alu_hazard = alu_valid_i && reg_conflict(hazard_i, alu_wr_reg_i);
  assign mem_hazard = (mem_valid_i || mem_busy_i) && reg_conflict(hazard_i, mem_wr_reg_i);

  assign ex_backpressure  = hazard_i.is_mul && stall_mul_o[0];
  assign alu_backpressure = !hazard_i.is_mul && stall_alu_o;

  assign stall_decode_o = dec_valid_i && (ex_backpressure || alu_backpressure ||
                                          alu_hazard || mem_hazard || mul_hazard);

  assign ex_bubble_o  = stall_decode_o && !ex_backpressure;
  assign alu_bubble_o = stall_decode_o && !stall_alu_o;

endmodule : hazard_unit

// File: logic/alu_stage.sv
`timescale 1ns/100ps
`include "backend_defs.svh"

module alu_stage import backend_pkg::*; (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic stall_i,
  op_if.dst    op_in,
  op_if.src    mem_out,
  op_if.src    wb_out
);

  logic                  valid_q;
  opcode_e               op_q;
  logic [`REG_IDX_W-1:0] rd_q;
  logic [`DATA_W-1:0]    opa_q;
  logic [`DATA_W-1:0]    opb_q;
  logic [`DATA_W-1:0]    result;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (!stall_i) begin
      valid_q <= op_in.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      op_q  <= op_in.op;
      rd_q  <= op_in.rd;
      opa_q <= op_in.opa;
      opb_q <= op_in.opb;
    end
  end

  // LOAD address is rs1 + imm
  assign result = (op_q == OP_SUB) ? (opa_q - opb_q) : (opa_q + opb_q);

  assign mem_out.valid = valid_q && (op_q == OP_LOAD);
  assign mem_out.op    = op_q;
  assign mem_out.rd    = rd_q;
  assign mem_out.opa   = result;
  assign mem_out.opb   = '0;
  assign mem_out.acc   = '0;

  assign wb_out.valid = valid_q && (op_q != OP_LOAD);
  assign wb_out.op    = op_q;
  assign wb_out.rd    = rd_q;
  assign wb_out.opa   = opa_q;
  assign wb_out.opb   = opb_q;
  assign wb_out.acc   = result;

endmodule : alu_stage

// File: logic/mul_stage.sv
`timescale 1ns/100ps
`include "backend_defs.svh"

module mul_stage import backend_pkg::*; #(
  parameter int STAGE_IDX = 0
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic stall_i,
  op_if.dst    up,
  op_if.src    down
);

  localparam int BITS = `DATA_W / `MUL_STAGES;
  localparam int BASE = BITS * STAGE_IDX;

  logic                  valid_q;
  opcode_e               op_q;
  logic [`REG_IDX_W-1:0] rd_q;
  logic [`DATA_W-1:0]    opa_q;
  logic [`DATA_W-1:0]    opb_q;
  logic [`DATA_W-1:0]    acc_q;
  logic [`DATA_W-1:0]    partial;

  // Shifted multiplicand for each set multiplier bit of this slice
  always_comb begin : partial_sum
    partial = up.acc;
    for (int k = 0; k < BITS; k++) begin
      if (up.opb[BASE+k]) begin
        partial = partial + (up.opa << (BASE + k));
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (!stall_i) begin
      valid_q <= up.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      op_q  <= up.op;
      rd_q  <= up.rd;
      opa_q <= up.opa;
      opb_q <= up.opb;
      acc_q <= partial;
    end
  end

  assign down.valid = valid_q;
  assign down.op    = op_q;
  assign down.rd    = rd_q;
  assign down.opa   = opa_q;
  assign down.opb   = opb_q;
  assign down.acc   = acc_q;

endmodule : mul_stage

// File: logic/mem_stage.sv
`timescale 1ns/100ps
`include "backend_defs.svh"

module mem_stage import backend_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,
  op_if.dst                  op_in,
  op_if.src                  wb_out,
  output logic               busy_o,
  output logic               mem_req_o,
  output logic [`DATA_W-1:0] mem_addr_o,
  input  logic               mem_ack_i,
  input  logic [`DATA_W-1:0] mem_rdata_i
);

  mem_state_e            state_q;
  logic                  res_valid_q;
  logic                  start;
  logic [`REG_IDX_W-1:0] rd_q;
  logic [`DATA_W-1:0]    addr_q;
  logic [`DATA_W-1:0]    data_q;

  // Busy until the result cycle has passed
  assign busy_o = (state_q != MEM_IDLE) || res_valid_q;
  assign start  = op_in.valid && !busy_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= MEM_IDLE;
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= 1'b0;
      case (state_q)
        MEM_IDLE: begin
          if (start) begin
            state_q <= MEM_REQ;
          end
        end
        MEM_REQ: begin
          if (mem_ack_i) begin
            state_q <= MEM_RELEASE;
          end
        end
        MEM_RELEASE: begin
          // Result shows in the cycle after ack goes low
          if (!mem_ack_i) begin
            state_q     <= MEM_IDLE;
            res_valid_q <= 1'b1;
          end
        end
        default: state_q <= MEM_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      addr_q <= op_in.opa;
      rd_q   <= op_in.rd;
    end
    if (state_q == MEM_REQ && mem_ack_i) begin
      data_q <= mem_rdata_i;
    end
  end

  assign mem_req_o  = (state_q == MEM_REQ);
  assign mem_addr_o = addr_q;

  assign wb_out.valid = res_valid_q;
  assign wb_out.op    = OP_LOAD;
  assign wb_out.rd    = rd_q;
  assign wb_out.opa   = addr_q;
  assign wb_out.opb   = '0;
  assign wb_out.acc   = data_q;

endmodule : mem_stage

// File: logic/writeback_arbiter.sv
`timescale 1ns/100ps
`include "backend_defs.svh"

module writeback_arbiter import backend_pkg::*; (
  op_if.dst                     mem_in,
  op_if.dst                     mul_in,
  op_if.dst                     alu_in,
  output logic                  mul_allowed_wb_o,
  output logic                  alu_allowed_wb_o,
  output logic                  wr_en_o,
  output logic [`REG_IDX_W-1:0] wr_rd_o,
  output logic [`DATA_W-1:0]    wr_data_o
);

  logic sel_valid;

  // Memory first, then last multiplier stage, then ALU
  always_comb begin : select
    sel_valid = alu_in.valid;
    wr_rd_o   = alu_in.rd;
    wr_data_o = alu_in.acc;
    if (mem_in.valid) begin
      sel_valid = 1'b1;
      wr_rd_o   = mem_in.rd;
      wr_data_o = mem_in.acc;
    end else if (mul_in.valid) begin
      sel_valid = 1'b1;
      wr_rd_o   = mul_in.rd;
      wr_data_o = mul_in.acc;
    end
  end

  assign wr_en_o          = sel_valid && (wr_rd_o != '0);
  assign mul_allowed_wb_o = !mem_in.valid;
  assign alu_allowed_wb_o = !mem_in.valid && !mul_in.valid;

endmodule : writeback_arbiter

// File: logic/exec_backend.sv
`timescale 1ns/100ps
`include "backend_defs.svh"

module exec_backend import backend_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  instr_valid_i,
  input  opcode_e               instr_op_i,
  input  logic [`REG_IDX_W-1:0] instr_rd_i,
  input  logic [`REG_IDX_W-1:0] instr_rs1_i,
  input  logic [`REG_IDX_W-1:0] instr_rs2_i,
  input  logic [`DATA_W-1:0]    instr_imm_i,
  output logic                  instr_ready_o,
  output logic                  wb_valid_o,
  output logic [`REG_IDX_W-1:0] wb_rd_o,
  output logic [`DATA_W-1:0]    wb_data_o,
  output logic                  mem_req_o,
  output logic [`DATA_W-1:0]    mem_addr_o,
  input  logic                  mem_ack_i,
  input  logic [`DATA_W-1:0]    mem_rdata_i
);

  op_if alu_in ();
  op_if mem_in ();
  op_if alu_out ();
  op_if mem_out ();
  op_if mul_chain [`MUL_STAGES+1] ();

  hazard_ctrl_t                           hazard;
  logic                                   stall_decode;
  logic                                   alu_bubble;
  logic                                   ex_bubble;
  logic                                   stall_alu;
  logic [`MUL_STAGES-1:0]                 stall_mul;
  logic [`MUL_STAGES-1:0]                 mul_valid;
  logic [`MUL_STAGES-1:0][`REG_IDX_W-1:0] mul_wr_reg;
  logic                                   mul_allowed_wb;
  logic                                   alu_allowed_wb;
  logic                                   mem_busy;
  logic                                   alu_valid;
  logic                                   alu_is_load;

  // ALU holds an op if either of its outputs is valid
  assign alu_valid   = alu_out.valid || mem_in.valid;
  assign alu_is_load = mem_in.valid;

  issue_stage u_issue (
    .clk_i, .rst_n_i,
    .instr_valid_i, .instr_op_i, .instr_rd_i, .instr_rs1_i, .instr_rs2_i, .instr_imm_i,
    .instr_ready_o,
    .stall_decode_i (stall_decode),
    .alu_bubble_i   (alu_bubble),
    .ex_bubble_i    (ex_bubble),
    .wr_en_i        (wb_valid_o),
    .wr_rd_i        (wb_rd_o),
    .wr_data_i      (wb_data_o),
    .hazard_o       (hazard),
    .alu_out        (alu_in),
    .mul_out        (mul_chain[0])
  );

  // rs1_needed marks a valid decode entry
  hazard_unit u_hazard (
    .dec_valid_i      (hazard.rs1_needed),
    .hazard_i         (hazard),
    .alu_valid_i      (alu_valid),
    .alu_is_load_i    (alu_is_load),
    .alu_wr_reg_i     (alu_out.rd),
    .mem_valid_i      (mem_out.valid),
    .mem_busy_i       (mem_busy),
    .mem_wr_reg_i     (mem_out.rd),
    .mul_valid_i      (mul_valid),
    .mul_wr_reg_i     (mul_wr_reg),
    .mul_allowed_wb_i (mul_allowed_wb),
    .alu_allowed_wb_i (alu_allowed_wb),
    .stall_mul_o      (stall_mul),
    .stall_alu_o      (stall_alu),
    .stall_decode_o   (stall_decode),
    .alu_bubble_o     (alu_bubble),
    .ex_bubble_o      (ex_bubble)
  );

  alu_stage u_alu (
    .clk_i, .rst_n_i,
    .stall_i (stall_alu),
    .op_in   (alu_in),
    .mem_out (mem_in),
    .wb_out  (alu_out)
  );

  for (genvar i = 0; i < `MUL_STAGES; i++) begin : g_mul
    mul_stage #(.STAGE_IDX(i)) u_mul (
      .clk_i, .rst_n_i,
      .stall_i (stall_mul[i]),
      .up      (mul_chain[i]),
      .down    (mul_chain[i+1])
    );
    assign mul_valid[i]  = mul_chain[i+1].valid;
    assign mul_wr_reg[i] = mul_chain[i+1].rd;
  end

  mem_stage u_mem (
    .clk_i, .rst_n_i,
    .op_in  (mem_in),
    .wb_out (mem_out),
    .busy_o (mem_busy),
    .mem_req_o, .mem_addr_o, .mem_ack_i, .mem_rdata_i
  );

  writeback_arbiter u_wb_arb (
    .mem_in           (mem_out),
    .mul_in           (mul_chain[`MUL_STAGES]),
    .alu_in           (alu_out),
    .mul_allowed_wb_o (mul_allowed_wb),
    .alu_allowed_wb_o (alu_allowed_wb),
    .wr_en_o          (wb_valid_o),
    .wr_rd_o          (wb_rd_o),
    .wr_data_o        (wb_data_o)
  );

endmodule : exec_backend

// File: verification/exec_backend_assert.sv
`timescale 1ns/100ps
`include "backend_defs.svh"

module exec_backend_assert (
  input logic                  clk_i,
  input logic                  rst_n_i,
  input logic                  mem_req_o,
  input logic [`DATA_W-1:0]    mem_addr_o,
  input logic                  mem_ack_i,
  input logic                  wb_valid_o,
  input logic [`REG_IDX_W-1:0] wb_rd_o
);

  // Address held for the whole request phase
  addr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_o && $past(mem_req_o) |-> $stable(mem_addr_o))
    else $error("mem_addr_o changed while mem_req_o was high");

  req_after_ack_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(mem_req_o) |-> !mem_ack_i)
    else $error("mem_req_o rose while mem_ack_i was still high");

  // Request stays up until acknowledged
  req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(mem_req_o) && !$past(mem_ack_i) |-> mem_req_o)
    else $error("mem_req_o dropped before mem_ack_i");

  no_r0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_valid_o |-> wb_rd_o != '0)
    else $error("writeback to register 0");

endmodule : exec_backend_assert

bind exec_backend exec_backend_assert u_assert (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .mem_req_o  (mem_req_o),
  .mem_addr_o (mem_addr_o),
  .mem_ack_i  (mem_ack_i),
  .wb_valid_o (wb_valid_o),
  .wb_rd_o    (wb_rd_o)
);

// File: verification/exec_backend_tb.sv
`timescale 1ns/100ps
`include "backend_defs.svh"

module exec_backend_tb import backend_pkg::*; ();

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  instr_valid_i;
  opcode_e               instr_op_i;
  logic [`REG_IDX_W-1:0] instr_rd_i;
  logic [`REG_IDX_W-1:0] instr_rs1_i;
  logic [`REG_IDX_W-1:0] instr_rs2_i;
  logic [`DATA_W-1:0]    instr_imm_i;
  logic                  instr_ready_o;
  logic                  wb_valid_o;
  logic [`REG_IDX_W-1:0] wb_rd_o;
  logic [`DATA_W-1:0]    wb_data_o;
  logic                  mem_req_o;
  logic [`DATA_W-1:0]    mem_addr_o;
  logic                  mem_ack_i;
  logic [`DATA_W-1:0]    mem_rdata_i;

  logic [31:0]        rng_state;
  string              test_name;
  logic [`DATA_W-1:0] model_regs [`NUM_REGS];
  // Expected writes per register with the oldest first
  logic [`DATA_W-1:0] exp_q [`NUM_REGS][$];

  exec_backend u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [`DATA_W-1:0] mem_word(input logic [`DATA_W-1:0] addr);
    return addr * 16'd3 + 16'd5;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic report_mismatch(input string what, input logic [`DATA_W-1:0] exp_val,
                                 input logic [`DATA_W-1:0] act_val);
    abort_run($sformatf("FAIL %s: %s expected %h actual %h",
                        test_name, what, exp_val, act_val));
  endtask

  // Four-phase responder that acks after 1 to 6 cycles
  initial begin : mem_responder
    int delay;
    int phase;
    mem_ack_i   = 1'b0;
    mem_rdata_i = '0;
    delay       = 0;
    phase       = 0;
    forever begin
      @(negedge clk_i);
      case (phase)
        0: begin
          if (mem_req_o) begin
            delay = 1 + int'(next_rand() % 32'd6);
            phase = 1;
          end
        end
        1: begin
          delay--;
          if (delay == 0) begin
            mem_rdata_i = mem_word(mem_addr_o);
            mem_ack_i   = 1'b1;
            phase       = 2;
          end
        end
        2: begin
          if (!mem_req_o) begin
            mem_ack_i = 1'b0;
            phase     = 0;
          end
        end
        default: phase = 0;
      endcase
    end
  end

  always @(negedge clk_i) begin
    if (rst_n_i && wb_valid_o) begin
      assert (exp_q[wb_rd_o].size() > 0)
        else abort_run($sformatf("unexpected write to r%0d in test %s", wb_rd_o, test_name));
      assert (wb_data_o == exp_q[wb_rd_o][0])
        else report_mismatch($sformatf("write to r%0d", wb_rd_o), exp_q[wb_rd_o][0], wb_data_o);
      void'(exp_q[wb_rd_o].pop_front());
    end
  end

  // Holds the instruction until accepted and records the expected write
  task automatic issue_instr(input opcode_e op, input logic [`REG_IDX_W-1:0] rd,
                             input logic [`REG_IDX_W-1:0] rs1,
                             input logic [`REG_IDX_W-1:0] rs2,
                             input logic [`DATA_W-1:0] imm);
    int                 waited;
    logic [`DATA_W-1:0] a;
    logic [`DATA_W-1:0] b;
    logic [`DATA_W-1:0] res;
    waited = 0;
    a = model_regs[rs1];
    b = model_regs[rs2];
    case (op)
      OP_ADD:  res = a + b;
      OP_SUB:  res = a - b;
      OP_MUL:  res = a * b;
      default: res = mem_word(a + imm);
    endcase
    @(negedge clk_i);
    instr_valid_i = 1'b1;
    instr_op_i    = op;
    instr_rd_i    = rd;
    instr_rs1_i   = rs1;
    instr_rs2_i   = rs2;
    instr_imm_i   = imm;
    #1;
    while (!instr_ready_o) begin
      @(negedge clk_i);
      #1;
      waited++;
      if (waited > 200) begin
        abort_run($sformatf("timeout waiting for instr_ready_o in test %s", test_name));
      end
    end
    if (rd != '0) begin
      model_regs[rd] = res;
      exp_q[rd].push_back(res);
    end
  endtask

  task automatic wait_drained();
    int waited;
    int pending;
    waited = 0;
    @(negedge clk_i);
    instr_valid_i = 1'b0;
    do begin
      @(negedge clk_i);
      #2;
      pending = 0;
      for (int r = 0; r < `NUM_REGS; r++) begin
        pending += exp_q[r].size();
      end
      waited++;
      if (waited > 500) begin
        abort_run($sformatf("timeout with %0d writes missing in test %s", pending, test_name));
      end
    end while (pending != 0);
    // Late duplicates would show up here
    repeat (8) @(negedge clk_i);
    for (int r = 0; r < `NUM_REGS; r++) begin
      assert (u_dut.u_issue.regs_q[r] == model_regs[r])
        else report_mismatch($sformatf("final r%0d", r), model_regs[r],
                             u_dut.u_issue.regs_q[r]);
    end
  endtask

  task automatic check_reset_state();
    test_name = "reset";
    #1;
    assert (!wb_valid_o) else report_mismatch("wb_valid_o", 16'd0, 16'(wb_valid_o));
    assert (!mem_req_o) else report_mismatch("mem_req_o", 16'd0, 16'(mem_req_o));
    assert (instr_ready_o) else report_mismatch("instr_ready_o", 16'd1, 16'(instr_ready_o));
  endtask

  task automatic load_and_use();
    test_name = "load";
    issue_instr(OP_LOAD, 3'd1, 3'd0, 3'd0, 16'h5000);
    issue_instr(OP_LOAD, 3'd2, 3'd0, 3'd0, 16'h1234);
    issue_instr(OP_LOAD, 3'd3, 3'd1, 3'd0, 16'h0007);
    issue_instr(OP_ADD,  3'd4, 3'd3, 3'd2, 16'h0000);
    issue_instr(OP_LOAD, 3'd5, 3'd0, 3'd0, 16'h4fff);
    issue_instr(OP_LOAD, 3'd6, 3'd4, 3'd0, 16'h0100);
    issue_instr(OP_SUB,  3'd7, 3'd6, 3'd5, 16'h0000);
    wait_drained();
  endtask

  task automatic add_sub_wrap();
    test_name = "add_sub";
    issue_instr(OP_ADD, 3'd5, 3'd1, 3'd3, 16'h0000);
    issue_instr(OP_ADD, 3'd0, 3'd1, 3'd3, 16'h0000);
    issue_instr(OP_SUB, 3'd6, 3'd2, 3'd1, 16'h0000);
    issue_instr(OP_ADD, 3'd7, 3'd3, 3'd3, 16'h0000);
    issue_instr(OP_SUB, 3'd4, 3'd1, 3'd2, 16'h0000);
    wait_drained();
  endtask

  task automatic mul_back_to_back();
    test_name = "mul";
    issue_instr(OP_MUL, 3'd4, 3'd1, 3'd2, 16'h0000);
    issue_instr(OP_MUL, 3'd5, 3'd2, 3'd3, 16'h0000);
    issue_instr(OP_MUL, 3'd6, 3'd3, 3'd1, 16'h0000);
    issue_instr(OP_MUL, 3'd7, 3'd1, 3'd1, 16'h0000);
    wait_drained();
  endtask

  task automatic dependent_chain();
    test_name = "dep_chain";
    issue_instr(OP_ADD, 3'd1, 3'd2, 3'd3, 16'h0000);
    issue_instr(OP_MUL, 3'd4, 3'd1, 3'd5, 16'h0000);
    issue_instr(OP_SUB, 3'd6, 3'd4, 3'd2, 16'h0000);
    issue_instr(OP_ADD, 3'd6, 3'd6, 3'd1, 16'h0000);
    issue_instr(OP_MUL, 3'd6, 3'd6, 3'd6, 16'h0000);
    issue_instr(OP_SUB, 3'd7, 3'd6, 3'd0, 16'h0000);
    wait_drained();
  endtask

  task automatic mixed_burst();
    logic [31:0]           r;
    logic [`REG_IDX_W-1:0] rd;
    test_name = "mixed_burst";
    issue_instr(OP_LOAD, 3'd1, 3'd0, 3'd0, 16'h2222);
    issue_instr(OP_MUL,  3'd2, 3'd3, 3'd4, 16'h0000);
    issue_instr(OP_ADD,  3'd5, 3'd6, 3'd7, 16'h0000);
    issue_instr(OP_SUB,  3'd3, 3'd5, 3'd2, 16'h0000);
    for (int n = 0; n < 20; n++) begin
      r  = next_rand();
      rd = (r[4:2] == '0) ? 3'd1 : r[4:2];
      issue_instr(opcode_e'(r[1:0]), rd, r[7:5], r[10:8], r[31:16]);
    end
    wait_drained();
  endtask

  initial begin
    rng_state     = 32'h0ebd_dd3f;
    test_name     = "init";
    rst_n_i       = 1'b0;
    instr_valid_i = 1'b0;
    instr_op_i    = OP_ADD;
    instr_rd_i    = '0;
    instr_rs1_i   = '0;
    instr_rs2_i   = '0;
    instr_imm_i   = '0;
    for (int r = 0; r < `NUM_REGS; r++) begin
      model_regs[r] = '0;
    end
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    check_reset_state();
    load_and_use();
    add_sub_wrap();
    mul_back_to_back();
    dependent_chain();
    mixed_burst();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule : exec_backend_tb

// File: exec_backend.f
+incdir+logic
logic/backend_pkg.sv
logic/op_if.sv
logic/issue_stage.sv
logic/hazard_unit.sv
logic/alu_stage.sv
logic/mul_stage.sv
logic/mem_stage.sv
logic/writeback_arbiter.sv
logic/exec_backend.sv
verification/exec_backend_assert.sv
verification/exec_backend_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module exec_backend_tb \
		-f exec_backend.f -o exec_backend_tb
	./obj_dir/exec_backend_tb

clean:
	rm -rf obj_dir
